// ==== Makefile ====
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --assert -Wno-fatal

SRCS := $(wildcard src/*.sv sim/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim.f ====
src/cpu_types_pkg.sv
src/cache_pkg.sv
src/dcache_stats.sv
src/mem_req_bridge.sv
src/dcache.sv
src/dcache_top.sv
sim/mem_model.sv
sim/dcache_tb.sv

// ==== sim/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;

   localparam int                   NUM_SETS   = 8;
   localparam cpu_types_pkg::word_t COUNT_ADDR = 32'h0000_3100;
   localparam int                   DEPTH      = 4096;
   // worst case transfers at 16 cycles each plus the memory load
   localparam int                   MAX_XFERS  = 1250;
   localparam int                   LIMIT      = DEPTH + MAX_XFERS * 16;

   localparam cpu_types_pkg::word_t BLK_A = 32'h0000_0100;
   localparam cpu_types_pkg::word_t EV_0  = 32'h0000_0010;
   localparam cpu_types_pkg::word_t EV_1  = 32'h0000_0410;
   localparam cpu_types_pkg::word_t EV_2  = 32'h0000_0810;

   logic                 CLK;
   logic                 nRST;
   logic                 dmem_ren;
   logic                 dmem_wen;
   cpu_types_pkg::word_t dmem_addr;
   cpu_types_pkg::word_t dmem_store;
   logic                 halt;
   logic                 mem_ack;
   cpu_types_pkg::word_t ext_rdata;
   logic                 dhit;
   cpu_types_pkg::word_t dmem_load;
   logic                 flushed;
   logic                 mem_req;
   logic                 mem_we;
   cpu_types_pkg::word_t ext_addr;
   cpu_types_pkg::word_t ext_wdata;
   logic [2:0]           ack_delay;
   logic                 load_en;
   logic [11:0]          load_addr;
   cpu_types_pkg::word_t load_data;

   cpu_types_pkg::word_t rand_state;
   cpu_types_pkg::word_t delay_state;
   int                   cycle_count = 0;

   // reference cache and memory
   cpu_types_pkg::word_t shadow   [DEPTH];
   cpu_types_pkg::word_t ref_blk  [2][NUM_SETS];
   cpu_types_pkg::word_t ref_data [2][NUM_SETS][2];
   logic                 ref_valid [2][NUM_SETS];
   logic                 ref_dirty [2][NUM_SETS];
   logic                 ref_lru   [NUM_SETS];
   int                   net;

   dcache_top #(
      .NUM_SETS   (NUM_SETS),
      .COUNT_ADDR (COUNT_ADDR)
   ) uut (
      .CLK        (CLK),
      .nRST       (nRST),
      .dmem_ren   (dmem_ren),
      .dmem_wen   (dmem_wen),
      .dmem_addr  (dmem_addr),
      .dmem_store (dmem_store),
      .halt       (halt),
      .mem_ack    (mem_ack),
      .ext_rdata  (ext_rdata),
      .dhit       (dhit),
      .dmem_load  (dmem_load),
      .flushed    (flushed),
      .mem_req    (mem_req),
      .mem_we     (mem_we),
      .ext_addr   (ext_addr),
      .ext_wdata  (ext_wdata)
   );

   mem_model #(
      .DEPTH (DEPTH)
   ) ext_mem (
      .CLK       (CLK),
      .nRST      (nRST),
      .mem_req   (mem_req),
      .mem_we    (mem_we),
      .ext_addr  (ext_addr),
      .ext_wdata (ext_wdata),
      .ack_delay (ack_delay),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data),
      .mem_ack   (mem_ack),
      .ext_rdata (ext_rdata)
   );

   initial
   begin
      CLK = 1'b0;
      forever #4 CLK = ~CLK;
   end

   function automatic cpu_types_pkg::word_t lcg_step(input cpu_types_pkg::word_t s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic cpu_types_pkg::word_t next_rand();
      rand_state = lcg_step(rand_state);
      return rand_state;
   endfunction

   // new ack delay every cycle from its own stream
   always @(negedge CLK)
   begin
      delay_state = lcg_step(delay_state);
      ack_delay   = 3'((delay_state >> 16) % 6);
   end

   always @(posedge CLK)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= LIMIT)
         stop_run($sformatf("timeout: no response from the DUT after %0d cycles", LIMIT));
   end

   // ==============================
   // checking
   task automatic stop_run(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check(input string name, input cpu_types_pkg::word_t exp,
                        input cpu_types_pkg::word_t act);
      if (exp !== act)
         stop_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
   endtask

   // ==============================
   // reference model and stimulus
   task automatic model_access(input cpu_types_pkg::word_t addr, input logic we,
                               input cpu_types_pkg::word_t data,
                               output cpu_types_pkg::word_t exp_load, output logic exp_hit);
      int                   set;
      int                   w;
      int                   way;
      cpu_types_pkg::word_t blk;
      blk     = addr >> 3;
      set     = blk % NUM_SETS;
      w       = addr[2];
      way     = 0;
      exp_hit = 1'b0;
      for (int i = 0; i < 2; i++)
      begin
         if (ref_valid[i][set] && ref_blk[i][set] == blk)
         begin
            exp_hit = 1'b1;
            way     = i;
         end
      end
      if (!exp_hit)
      begin
         way = !ref_lru[set];
         // dirty victim goes back to memory first
         if (ref_dirty[way][set])
         begin
            shadow[ref_blk[way][set] * 2]     = ref_data[way][set][0];
            shadow[ref_blk[way][set] * 2 + 1] = ref_data[way][set][1];
         end
         ref_data[way][set][0] = shadow[blk * 2];
         ref_data[way][set][1] = shadow[blk * 2 + 1];
         ref_blk[way][set]     = blk;
         ref_valid[way][set]   = 1'b1;
         ref_dirty[way][set]   = 1'b0;
         net                   = net - 1;
      end
      // the access itself is served as a hit even after a fill
      net          = net + 1;
      ref_lru[set] = way[0];
      if (we)
      begin
         ref_data[way][set][w] = data;
         ref_dirty[way][set]   = 1'b1;
      end
      exp_load = ref_data[way][set][w];
   endtask

   task automatic cpu_access(input logic we, input cpu_types_pkg::word_t addr,
                             input cpu_types_pkg::word_t data,
                             output cpu_types_pkg::word_t load, output logic hit);
      int waited;
      waited = 0;
      @(negedge CLK);
      dmem_ren   = !we;
      dmem_wen   = we;
      dmem_addr  = addr;
      dmem_store = data;
      #2;
      while (!dhit)
      begin
         @(negedge CLK);
         #2;
         waited++;
      end
      load = dmem_load;
      hit  = (waited == 0);
   endtask

   task automatic access_and_check(input string name, input logic we,
                                   input cpu_types_pkg::word_t addr,
                                   input cpu_types_pkg::word_t data,
                                   output cpu_types_pkg::word_t load, output logic hit);
      cpu_types_pkg::word_t exp_load;
      logic                 exp_hit;
      model_access(addr, we, data, exp_load, exp_hit);
      cpu_access(we, addr, data, load, hit);
      check({name, " hit"}, exp_hit, hit);
      if (!we)
         check(name, exp_load, load);
   endtask

   task automatic fill_memory();
      for (int a = 0; a < DEPTH; a++)
      begin
         @(negedge CLK);
         load_en   = 1'b1;
         load_addr = a[11:0];
         load_data = next_rand();
         shadow[a] = load_data;
      end
      @(negedge CLK);
      load_en = 1'b0;
   endtask

   // ==============================
   // tests
   task automatic read_block_test();
      cpu_types_pkg::word_t load;
      logic                 hit;
      access_and_check("read_block word0", 1'b0, BLK_A, '0, load, hit);
      check("read_block word0 data", shadow[BLK_A >> 2], load);
      check("read_block word0 miss", 1'b0, hit);
      access_and_check("read_block word1", 1'b0, BLK_A + 4, '0, load, hit);
      check("read_block word1 data", shadow[(BLK_A >> 2) + 1], load);
      check("read_block word1 hit", 1'b1, hit);
   endtask

   task automatic write_hit_test();
      cpu_types_pkg::word_t load;
      cpu_types_pkg::word_t old;
      logic                 hit;
      old = shadow[BLK_A >> 2];
      access_and_check("write_hit store", 1'b1, BLK_A, 32'hCAFE_0001, load, hit);
      check("write_hit store hit", 1'b1, hit);
      access_and_check("write_hit reload", 1'b0, BLK_A, '0, load, hit);
      check("write_hit reload data", 32'hCAFE_0001, load);
      check("write_hit memory unchanged", old, ext_mem.words[BLK_A >> 2]);
   endtask

   task automatic eviction_test();
      cpu_types_pkg::word_t load;
      logic                 hit;
      access_and_check("evict dirty", 1'b1, EV_0, 32'h5EED_0010, load, hit);
      access_and_check("evict second tag", 1'b0, EV_1, '0, load, hit);
      // third tag replaces the dirty block
      access_and_check("evict third tag", 1'b0, EV_2, '0, load, hit);
      check("evict written word", 32'h5EED_0010, ext_mem.words[EV_0 >> 2]);
      check("evict other word", shadow[(EV_0 >> 2) + 1], ext_mem.words[(EV_0 >> 2) + 1]);
      access_and_check("evict reread", 1'b0, EV_0, '0, load, hit);
      check("evict reread miss", 1'b0, hit);
      check("evict reread data", 32'h5EED_0010, load);
   endtask

   task automatic random_test();
      cpu_types_pkg::word_t r;
      cpu_types_pkg::word_t load;
      logic                 hit;
      for (int n = 0; n < 200; n++)
      begin
         r = next_rand();
         access_and_check("random", r[31], r & 32'h0000_01FC, next_rand(), load, hit);
      end
   endtask

   task automatic flush_test();
      @(negedge CLK);
      dmem_ren = 1'b0;
      dmem_wen = 1'b0;
      halt     = 1'b1;
      while (!flushed)
         @(negedge CLK);
      // count store still in flight
      while (!mem_ack)
         @(negedge CLK);
      while (mem_ack)
         @(negedge CLK);
      check("flush count", net, ext_mem.words[COUNT_ADDR >> 2]);
      for (int w = 0; w < 2; w++)
      begin
         for (int s = 0; s < NUM_SETS; s++)
         begin
            if (ref_dirty[w][s])
            begin
               shadow[ref_blk[w][s] * 2]     = ref_data[w][s][0];
               shadow[ref_blk[w][s] * 2 + 1] = ref_data[w][s][1];
            end
         end
      end
      shadow[COUNT_ADDR >> 2] = net;
      for (int a = 0; a < DEPTH; a++)
         check("flush memory", shadow[a], ext_mem.words[a]);
      repeat (5) @(negedge CLK);
      check("flushed held", 1'b1, flushed);
   endtask

   initial
   begin
      nRST        = 1'b0;
      dmem_ren    = 1'b0;
      dmem_wen    = 1'b0;
      dmem_addr   = '0;
      dmem_store  = '0;
      halt        = 1'b0;
      ack_delay   = 3'd0;
      load_en     = 1'b0;
      load_addr   = '0;
      load_data   = '0;
      rand_state  = 32'd59960;
      delay_state = 32'd59960;
      net         = 0;
      for (int s = 0; s < NUM_SETS; s++)
      begin
         ref_lru[s] = 1'b0;
         for (int w = 0; w < 2; w++)
         begin
            ref_valid[w][s] = 1'b0;
            ref_dirty[w][s] = 1'b0;
         end
      end
      repeat (10) @(posedge CLK);
      @(negedge CLK);
      nRST = 1'b1;
      fill_memory();
      read_block_test();
      write_hit_test();
      eviction_test();
      random_test();
      flush_test();
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// ==== sim/mem_model.sv ====
`timescale 1ns/1ps

module mem_model #(
   parameter int DEPTH = 4096
) (
   input  logic                     CLK,
   input  logic                     nRST,
   input  logic                     mem_req,
   input  logic                     mem_we,
   input  cpu_types_pkg::word_t     ext_addr,
   input  cpu_types_pkg::word_t     ext_wdata,
   input  logic [2:0]               ack_delay,
   input  logic                     load_en,
   input  logic [$clog2(DEPTH)-1:0] load_addr,
   input  cpu_types_pkg::word_t     load_data,
   output logic                     mem_ack,
   output cpu_types_pkg::word_t     ext_rdata
);

   localparam int IDX_W = $clog2(DEPTH);

   cpu_types_pkg::word_t words [DEPTH];
   logic                 busy;
   logic [2:0]           wait_q;
   logic                 fire;
   logic [IDX_W-1:0]     idx;

   assign idx  = ext_addr[IDX_W+1:2];
   assign fire = busy && (wait_q == 3'd0);

   // ==============================
   // four-phase responder
   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         busy    <= 1'b0;
         wait_q  <= 3'd0;
         mem_ack <= 1'b0;
      end
      else if (mem_ack)
      begin
         // ack held until the request drops
         if (!mem_req)
            mem_ack <= 1'b0;
      end
      else if (fire)
      begin
         busy    <= 1'b0;
         mem_ack <= 1'b1;
      end
      else if (busy)
         wait_q <= wait_q - 3'd1;
      else if (mem_req)
      begin
         busy   <= 1'b1;
         wait_q <= ack_delay;
      end
   end

   always_ff @(posedge CLK)
   begin
      if (load_en)
         words[load_addr] <= load_data;
      else if (fire && mem_we)
         words[idx] <= ext_wdata;
      if (fire && !mem_we)
         ext_rdata <= words[idx];
   end

endmodule

// ==== src/cache_pkg.sv ====
package cache_pkg;

   // data cache controller
   typedef enum logic [3:0] {
      IDLE,
      WB1,
      WB2,
      READ1,
      READ2,
      FLUSH_SCAN,
      FLUSH1,
      FLUSH2,
      COUNT,
      HALTED
   } dcache_state_t;

   // operation presented to the memory bridge
   typedef enum logic [1:0] {
      MEM_NONE,
      MEM_READ,
      MEM_WRITE
   } mem_op_t;

endpackage

// ==== src/cpu_types_pkg.sv ====
package cpu_types_pkg;

   // byte addresses, words are four bytes
   localparam int ADDR_BITS = 32;

   // data and address words share one type
   typedef logic [ADDR_BITS-1:0] word_t;

endpackage

// ==== src/dcache.sv ====
`timescale 1ns/1ps

module dcache #(
   parameter int                   NUM_SETS   = 8,
   parameter cpu_types_pkg::word_t COUNT_ADDR = 32'h0000_3100
) (
   input  logic                 CLK,
   input  logic                 nRST,
   input  logic                 dmem_ren,
   input  logic                 dmem_wen,
   input  cpu_types_pkg::word_t dmem_addr,
   input  cpu_types_pkg::word_t dmem_store,
   input  logic                 halt,
   input  logic                 dwait,
   input  cpu_types_pkg::word_t mem_rdata,
   input  cpu_types_pkg::word_t hit_count,
   output logic                 dhit,
   output cpu_types_pkg::word_t dmem_load,
   output logic                 flushed,
   output cache_pkg::mem_op_t   mem_op,
   output cpu_types_pkg::word_t mem_addr,
   output cpu_types_pkg::word_t mem_wdata,
   output logic                 hit_evt,
   output logic                 miss_evt
);

   localparam int IDX_W = $clog2(NUM_SETS);
   // two words per block, byte offset below that
   localparam int TAG_W = cpu_types_pkg::ADDR_BITS - IDX_W - 3;

   // ==============================
   // arrays
   logic [TAG_W-1:0]     tag_mem  [2][NUM_SETS];
   cpu_types_pkg::word_t data_mem [2][NUM_SETS][2];
   logic                 valid    [2][NUM_SETS];
   logic                 dirty    [2][NUM_SETS];
   logic                 lru      [NUM_SETS];

   cache_pkg::dcache_state_t state;
   cache_pkg::dcache_state_t next_state;
   logic                     miss_way;
   logic [IDX_W:0]           scan_q;

   logic [TAG_W-1:0] req_tag;
   logic [IDX_W-1:0] req_idx;
   logic             req_word;
   logic [1:0]       way_hit;
   logic             hit;
   logic             hit_way;
   logic             access;
   logic             victim;
   logic             victim_dirty;
   logic             scan_way;
   logic [IDX_W-1:0] scan_set;
   logic             beat;

   assign req_tag  = dmem_addr[cpu_types_pkg::ADDR_BITS-1 -: TAG_W];
   assign req_idx  = dmem_addr[IDX_W+2:3];
   assign req_word = dmem_addr[2];
   assign access   = dmem_ren | dmem_wen;

   assign way_hit[0] = valid[0][req_idx] && (tag_mem[0][req_idx] == req_tag);
   assign way_hit[1] = valid[1][req_idx] && (tag_mem[1][req_idx] == req_tag);
   assign hit        = |way_hit;
   assign hit_way    = way_hit[1];

   // replace the way not used last
   assign victim       = ~lru[req_idx];
   assign victim_dirty = dirty[victim][req_idx];

   // scan walks way 0 of every set, then way 1
   assign scan_way = scan_q[IDX_W];
   assign scan_set = scan_q[IDX_W-1:0];

   assign beat = (state == cache_pkg::WB2) || (state == cache_pkg::READ2) ||
                 (state == cache_pkg::FLUSH2);

   assign dhit      = (state == cache_pkg::IDLE) && !halt && access && hit;
   assign miss_evt  = (state == cache_pkg::IDLE) && !halt && access && !hit;
   assign hit_evt   = dhit;
   assign dmem_load = data_mem[hit_way][req_idx][req_word];

   // ==============================
   // next state
   always_comb
   begin
      next_state = state;
      case (state)
         cache_pkg::IDLE:
            if (halt)
               next_state = cache_pkg::FLUSH_SCAN;
            else if (miss_evt)
               next_state = victim_dirty ? cache_pkg::WB1 : cache_pkg::READ1;
         cache_pkg::WB1:
            if (!dwait)
               next_state = cache_pkg::WB2;
         cache_pkg::WB2:
            if (!dwait)
               next_state = cache_pkg::READ1;
         cache_pkg::READ1:
            if (!dwait)
               next_state = cache_pkg::READ2;
         cache_pkg::READ2:
            if (!dwait)
               next_state = cache_pkg::IDLE;
         cache_pkg::FLUSH_SCAN:
            if (dirty[scan_way][scan_set])
               next_state = cache_pkg::FLUSH1;
            else if (&scan_q)
               next_state = cache_pkg::COUNT;
         cache_pkg::FLUSH1:
            if (!dwait)
               next_state = cache_pkg::FLUSH2;
         cache_pkg::FLUSH2:
            if (!dwait)
               next_state = cache_pkg::FLUSH_SCAN;
         cache_pkg::COUNT:
            if (!dwait)
               next_state = cache_pkg::HALTED;
         cache_pkg::HALTED:
            next_state = cache_pkg::HALTED;
         default:
            next_state = cache_pkg::IDLE;
      endcase
   end

   // ==============================
   // control state and block flags
   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         state    <= cache_pkg::IDLE;
         miss_way <= 1'b0;
         scan_q   <= '0;
         for (int s = 0; s < NUM_SETS; s++)
         begin
            lru[s] <= 1'b0;
            for (int w = 0; w < 2; w++)
            begin
               valid[w][s] <= 1'b0;
               dirty[w][s] <= 1'b0;
            end
         end
      end
      else
      begin
         state <= next_state;
         case (state)
            cache_pkg::IDLE:
            begin
               if (dhit)
               begin
                  lru[req_idx] <= hit_way;
                  if (dmem_wen)
                     dirty[hit_way][req_idx] <= 1'b1;
               end
               if (miss_evt)
                  miss_way <= victim;
               if (halt)
                  scan_q <= '0;
            end
            // block installed clean
            cache_pkg::READ2:
               if (!dwait)
               begin
                  valid[miss_way][req_idx] <= 1'b1;
                  dirty[miss_way][req_idx] <= 1'b0;
               end
            cache_pkg::FLUSH_SCAN:
               if (!dirty[scan_way][scan_set] && !(&scan_q))
                  scan_q <= scan_q + 1'b1;
            cache_pkg::FLUSH2:
               if (!dwait)
                  dirty[scan_way][scan_set] <= 1'b0;
            default:
               ;
         endcase
      end
   end

   always_ff @(posedge CLK)
   begin
      if (dhit && dmem_wen)
         data_mem[hit_way][req_idx][req_word] <= dmem_store;
      if (state == cache_pkg::READ1 && !dwait)
         data_mem[miss_way][req_idx][0] <= mem_rdata;
      if (state == cache_pkg::READ2 && !dwait)
      begin
         data_mem[miss_way][req_idx][1] <= mem_rdata;
         tag_mem[miss_way][req_idx]     <= req_tag;
      end
   end

   // ==============================
   // memory side
   always_comb
   begin
      mem_op    = cache_pkg::MEM_NONE;
      mem_addr  = '0;
      mem_wdata = '0;
      flushed   = 1'b0;
      case (state)
         cache_pkg::WB1, cache_pkg::WB2:
         begin
            mem_op    = cache_pkg::MEM_WRITE;
            mem_addr  = {tag_mem[miss_way][req_idx], req_idx, beat, 2'b00};
            mem_wdata = data_mem[miss_way][req_idx][beat];
         end
         cache_pkg::READ1, cache_pkg::READ2:
         begin
            mem_op   = cache_pkg::MEM_READ;
            mem_addr = {req_tag, req_idx, beat, 2'b00};
         end
         cache_pkg::FLUSH1, cache_pkg::FLUSH2:
         begin
            mem_op    = cache_pkg::MEM_WRITE;
            mem_addr  = {tag_mem[scan_way][scan_set], scan_set, beat, 2'b00};
            mem_wdata = data_mem[scan_way][scan_set][beat];
         end
         // final store of the net hit count
         cache_pkg::COUNT:
         begin
            mem_op    = cache_pkg::MEM_WRITE;
            mem_addr  = COUNT_ADDR;
            mem_wdata = hit_count;
            flushed   = 1'b1;
         end
         cache_pkg::HALTED:
            flushed = 1'b1;
         default:
            ;
      endcase
   end

   assert property (@(posedge CLK) disable iff (!nRST) !(dhit && flushed));

   // bridge latches op and address once, so both hold until the word is done
   assert property (@(posedge CLK) disable iff (!nRST)
      ($past(dwait) && $past(mem_op) != cache_pkg::MEM_NONE) |->
         (mem_op == $past(mem_op) && mem_addr == $past(mem_addr)));

endmodule

// ==== src/dcache_stats.sv ====
`timescale 1ns/1ps

module dcache_stats (
   input  logic                 CLK,
   input  logic                 nRST,
   input  logic                 hit_evt,
   input  logic                 miss_evt,
   output cpu_types_pkg::word_t hit_count
);

   logic signed [$bits(cpu_types_pkg::word_t)-1:0] net_q;
   logic signed [1:0]                              step;

   // +1 per hit, -1 per miss
   always_comb
   begin
      step = 2'sd0;
      if (hit_evt)
         step = 2'sd1;
      else if (miss_evt)
         step = -2'sd1;
   end

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         net_q <= '0;
      end
      else
      begin
         net_q <= net_q + step;
      end
   end

   assign hit_count = net_q;

   // the controller reports a request as either a hit or a miss, never both
   assert property (@(posedge CLK) disable iff (!nRST) !(hit_evt && miss_evt));

endmodule

// ==== src/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top #(
   parameter int                   NUM_SETS   = 8,
   parameter cpu_types_pkg::word_t COUNT_ADDR = 32'h0000_3100
) (
   input  logic                 CLK,
   input  logic                 nRST,
   input  logic                 dmem_ren,
   input  logic                 dmem_wen,
   input  cpu_types_pkg::word_t dmem_addr,
   input  cpu_types_pkg::word_t dmem_store,
   input  logic                 halt,
   input  logic                 mem_ack,
   input  cpu_types_pkg::word_t ext_rdata,
   output logic                 dhit,
   output cpu_types_pkg::word_t dmem_load,
   output logic                 flushed,
   output logic                 mem_req,
   output logic                 mem_we,
   output cpu_types_pkg::word_t ext_addr,
   output cpu_types_pkg::word_t ext_wdata
);

   cache_pkg::mem_op_t   mem_op;
   cpu_types_pkg::word_t mem_addr;
   cpu_types_pkg::word_t mem_wdata;
   cpu_types_pkg::word_t mem_rdata;
   cpu_types_pkg::word_t hit_count;
   logic                 dwait;
   logic                 hit_evt;
   logic                 miss_evt;

   dcache #(
      .NUM_SETS   (NUM_SETS),
      .COUNT_ADDR (COUNT_ADDR)
   ) u_dcache (
      .CLK        (CLK),
      .nRST       (nRST),
      .dmem_ren   (dmem_ren),
      .dmem_wen   (dmem_wen),
      .dmem_addr  (dmem_addr),
      .dmem_store (dmem_store),
      .halt       (halt),
      .dwait      (dwait),
      .mem_rdata  (mem_rdata),
      .hit_count  (hit_count),
      .dhit       (dhit),
      .dmem_load  (dmem_load),
      .flushed    (flushed),
      .mem_op     (mem_op),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .hit_evt    (hit_evt),
      .miss_evt   (miss_evt)
   );

   dcache_stats u_stats (
      .CLK       (CLK),
      .nRST      (nRST),
      .hit_evt   (hit_evt),
      .miss_evt  (miss_evt),
      .hit_count (hit_count)
   );

   mem_req_bridge u_bridge (
      .CLK       (CLK),
      .nRST      (nRST),
      .mem_op    (mem_op),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_ack   (mem_ack),
      .ext_rdata (ext_rdata),
      .dwait     (dwait),
      .mem_rdata (mem_rdata),
      .mem_req   (mem_req),
      .mem_we    (mem_we),
      .ext_addr  (ext_addr),
      .ext_wdata (ext_wdata)
   );

endmodule

// ==== src/mem_req_bridge.sv ====
`timescale 1ns/1ps

module mem_req_bridge (
   input  logic                 CLK,
   input  logic                 nRST,
   input  cache_pkg::mem_op_t   mem_op,
   input  cpu_types_pkg::word_t mem_addr,
   input  cpu_types_pkg::word_t mem_wdata,
   input  logic                 mem_ack,
   input  cpu_types_pkg::word_t ext_rdata,
   output logic                 dwait,
   output cpu_types_pkg::word_t mem_rdata,
   output logic                 mem_req,
   output logic                 mem_we,
   output cpu_types_pkg::word_t ext_addr,
   output cpu_types_pkg::word_t ext_wdata
);

   typedef enum logic [1:0] {
      BR_IDLE,
      BR_REQ,
      BR_REL,
      BR_DONE
   } br_state_t;

   br_state_t state;

   // ==============================
   // four-phase sequencer
   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         state   <= BR_IDLE;
         mem_req <= 1'b0;
         mem_we  <= 1'b0;
      end
      else
      begin
         case (state)
            BR_IDLE:
               if (mem_op != cache_pkg::MEM_NONE)
               begin
                  state   <= BR_REQ;
                  mem_req <= 1'b1;
                  mem_we  <= (mem_op == cache_pkg::MEM_WRITE);
               end
            BR_REQ:
               if (mem_ack)
               begin
                  state   <= BR_REL;
                  mem_req <= 1'b0;
                  mem_we  <= 1'b0;
               end
            // wait for memory to drop ack
            BR_REL:
               if (!mem_ack)
                  state <= BR_DONE;
            default:
               state <= BR_IDLE;
         endcase
      end
   end

   always_ff @(posedge CLK)
   begin
      if (state == BR_IDLE && mem_op != cache_pkg::MEM_NONE)
      begin
         ext_addr  <= mem_addr;
         ext_wdata <= mem_wdata;
      end
      if (state == BR_REQ && mem_ack)
         mem_rdata <= ext_rdata;
   end

   // one cycle low per finished word
   assign dwait = (state != BR_DONE);

   assert property (@(posedge CLK) disable iff (!nRST) $fell(mem_req) |-> $past(mem_ack));

   assert property (@(posedge CLK) disable iff (!nRST)
      (mem_req && $past(mem_req)) |-> $stable(ext_addr));

endmodule
